// File: Makefile
# Verilator build and run of the UART debug subsystem testbench

VERILATOR ?= verilator
FILELIST  ?= project.f
TB_TOP    ?= tb_dbg_tile
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST) | grep -v '^+') include/dbg_cfg.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "Test did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tb_clkgen.sv
// Free-running testbench clock
// Period is CLK_PERIOD in ns, starting low at time zero

`timescale 1ns/1ns
`default_nettype none

module tb_clkgen #(
   parameter int CLK_PERIOD = 10
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk_o = ~clk_o;
      end
   end

endmodule

`default_nettype wire

// File: dv/tb_dbg_tile.sv
// Testbench for the UART debug subsystem
// Acts as the UART host and checks replies against a memory model

`timescale 1ns/1ns
`default_nettype none

`include "dbg_cfg.svh"

module tb_dbg_tile;

   import dbg_pkg::*;

   localparam int unsigned SEED = 32'h4820d65f;
   localparam int BIT_CLKS  = 16 * `DBG_CLKS_PER_TICK;
   localparam int RAM_WORDS = `DBG_RAM_WORDS;
   localparam int N_WRITES  = 40;
   localparam int N_READS   = 40;
   localparam int N_RANGE   = 6;
   localparam int N_RST     = 8;
   localparam int N_UNK     = 4;
   // Longest command is a write, 7 bytes out and 1 back, plus slack
   localparam int CMD_MAX_CLKS = 9 * 10 * BIT_CLKS;
   localparam int NUM_CMDS  = N_WRITES + N_READS + N_RANGE + N_RST + N_UNK + 1;

   logic clk;
   logic reset_i;
   logic uart_rx_i;
   logic uart_tx_o;
   logic cpu_rst_o;

   byte_t    cmd_bytes[$];
   byte_t    reply_bytes[$];
   wb_data_t model[int];
   wb_addr_t written[$];

   tb_clkgen #(.CLK_PERIOD(10)) u_clkgen (.clk_o(clk));

   dbg_tile_top u_dbg_tile_top (
      .clk       (clk),
      .reset_i   (reset_i),
      .uart_rx_i (uart_rx_i),
      .uart_tx_o (uart_tx_o),
      .cpu_rst_o (cpu_rst_o)
   );

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAILED at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
         $display("SIMULATION FAILED");
         $fatal(1, "Value mismatch");
      end
   endtask

   // 8N1 frame on the host line, bits change on the falling edge
   task automatic send_byte(input byte_t b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(negedge clk);
         uart_rx_i = frame[i];
         repeat (BIT_CLKS - 1) @(negedge clk);
      end
   endtask

   task automatic recv_byte(output byte_t b);
      int wait_cnt;
      wait_cnt = 0;
      @(negedge clk);
      while (uart_tx_o !== 1'b0 && wait_cnt <= CMD_MAX_CLKS) begin
         wait_cnt++;
         @(negedge clk);
      end
      if (wait_cnt > CMD_MAX_CLKS) begin
         $display("No reply start bit on uart_tx_o within %0d cycles at %0t ns",
                  CMD_MAX_CLKS, $time);
         $display("SIMULATION FAILED");
         $fatal(1, "Reply timeout");
      end
      // Mid start bit, then one sample per bit period
      repeat (BIT_CLKS / 2) @(negedge clk);
      check("uart_tx_o start bit", uart_tx_o, 1'b0);
      for (int i = 0; i < 8; i++) begin
         repeat (BIT_CLKS) @(negedge clk);
         b[i] = uart_tx_o;
      end
      repeat (BIT_CLKS) @(negedge clk);
      check("uart_tx_o stop bit", uart_tx_o, 1'b1);
   endtask

   task automatic recv_reply(input int n);
      byte_t b;
      reply_bytes.delete();
      repeat (n) begin
         recv_byte(b);
         reply_bytes.push_back(b);
      end
   endtask

   // Reply may start before the last stop bit is over, so listen in parallel
   task automatic run_cmd(input int n_reply);
      fork
         begin
            foreach (cmd_bytes[i]) begin
               send_byte(cmd_bytes[i]);
            end
         end
         begin
            recv_reply(n_reply);
         end
      join
   endtask

   task automatic write_word(input wb_addr_t addr, input wb_data_t data);
      byte_t exp;
      exp = (addr < RAM_WORDS) ? REPLY_OK : REPLY_ERR;
      cmd_bytes.delete();
      cmd_bytes.push_back(CMD_WRITE);
      cmd_bytes.push_back(addr[15:8]);
      cmd_bytes.push_back(addr[7:0]);
      for (int i = 3; i >= 0; i--) begin
         cmd_bytes.push_back(data[8*i +: 8]);
      end
      run_cmd(1);
      check($sformatf("write[%h] reply", addr), reply_bytes[0], exp);
      if (addr < RAM_WORDS) begin
         if (!model.exists(int'(addr))) begin
            written.push_back(addr);
         end
         model[int'(addr)] = data;
      end
   endtask

   task automatic read_word(input wb_addr_t addr);
      wb_data_t exp;
      cmd_bytes.delete();
      cmd_bytes.push_back(CMD_READ);
      cmd_bytes.push_back(addr[15:8]);
      cmd_bytes.push_back(addr[7:0]);
      if (addr >= RAM_WORDS) begin
         run_cmd(1);
         check($sformatf("read[%h] reply", addr), reply_bytes[0], REPLY_ERR);
      end else begin
         exp = model[int'(addr)];
         run_cmd(4);
         for (int i = 0; i < 4; i++) begin
            check($sformatf("read[%h] byte %0d", addr, i), reply_bytes[i], exp[31-8*i -: 8]);
         end
      end
   endtask

   task automatic cpu_reset(input byte_t arg);
      cmd_bytes.delete();
      cmd_bytes.push_back(CMD_CPU_RST);
      cmd_bytes.push_back(arg);
      run_cmd(1);
      check("cpu_rst reply", reply_bytes[0], REPLY_OK);
      check("cpu_rst_o", cpu_rst_o, arg[0]);
   endtask

   initial begin
      repeat (NUM_CMDS * CMD_MAX_CLKS * 2) @(posedge clk);
      $display("Watchdog expired, the run took longer than all commands allow");
      $display("SIMULATION FAILED");
      $fatal(1, "Watchdog");
   end

   initial begin
      wb_addr_t    addr;
      byte_t       code;
      int          idx;
      reset_i   = 1'b1;
      uart_rx_i = 1'b1;
      void'($urandom(SEED));
      repeat (16) @(negedge clk);
      reset_i = 1'b0;

      // Idle line and CPU held after reset
      repeat (200) begin
         @(negedge clk);
         check("uart_tx_o idle", uart_tx_o, 1'b1);
         check("cpu_rst_o after reset", cpu_rst_o, 1'b1);
      end

      repeat (N_WRITES) begin
         addr = wb_addr_t'($urandom_range(0, RAM_WORDS - 1));
         write_word(addr, $urandom());
      end

      repeat (N_READS) begin
         idx = $urandom_range(0, written.size() - 1);
         read_word(written[idx]);
      end

      // Range edges and beyond
      write_word(wb_addr_t'(RAM_WORDS - 1), $urandom());
      write_word(wb_addr_t'(0), $urandom());
      write_word(wb_addr_t'(RAM_WORDS), $urandom());
      addr = wb_addr_t'($urandom_range(RAM_WORDS, 16'hFFFF));
      read_word(addr);
      read_word(wb_addr_t'(RAM_WORDS - 1));
      // Word 0 shares its low address bits with RAM_WORDS
      read_word(wb_addr_t'(0));

      repeat (N_RST) begin
         cpu_reset(byte_t'($urandom_range(0, 255)));
      end

      repeat (N_UNK) begin
         do begin
            code = byte_t'($urandom_range(0, 255));
         end while (code == CMD_WRITE || code == CMD_READ || code == CMD_CPU_RST);
         cmd_bytes.delete();
         cmd_bytes.push_back(code);
         run_cmd(1);
         check($sformatf("unknown cmd %h reply", code), reply_bytes[0], REPLY_ERR);
      end

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: include/dbg_cfg.svh
// Build-time settings of the UART debug subsystem
// Include this file wherever tick timing, RAM size or the command timeout is needed

`ifndef DBG_CFG_SVH
`define DBG_CFG_SVH

// Clock cycles per 16x oversample tick
// One UART bit is 16 ticks, so 32 clocks at the default
`define DBG_CLKS_PER_TICK 2

// Number of 32-bit words in the Wishbone RAM
// Word addresses at or above this value get an error response
`define DBG_RAM_WORDS 256

// Clock cycles a partly received command may stall before it is dropped
`define DBG_CMD_TIMEOUT 4096

`endif

// File: project.f
+incdir+include
verilog/dbg_pkg.sv
verilog/uart_tick_timer.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/dbg_cmd_fsm.sv
verilog/wb_ram.sv
verilog/dbg_tile_top.sv
dv/tb_clkgen.sv
dv/tb_dbg_tile.sv

// File: verilog/dbg_cmd_fsm.sv
// Host command decoder between the UART and the Wishbone bus
// Gathers command bytes, runs one word access or sets the CPU reset hold, then replies

`timescale 1ns/1ns
`default_nettype none

`include "dbg_cfg.svh"

module dbg_cmd_fsm (
   input  logic             clk,
   input  logic             reset_i,
   input  dbg_pkg::byte_t   rx_byte_i,
   input  logic             rx_valid_i,
   input  logic             tx_busy_i,
   output dbg_pkg::byte_t   tx_byte_o,
   output logic             tx_start_o,
   output logic             wb_cyc_o,
   output logic             wb_stb_o,
   output logic             wb_we_o,
   output dbg_pkg::wb_addr_t wb_adr_o,
   output dbg_pkg::wb_data_t wb_dat_o,
   input  dbg_pkg::wb_data_t wb_dat_i,
   input  logic             wb_ack_i,
   input  logic             wb_err_i,
   output logic             cpu_rst_o
);

   import dbg_pkg::*;

   localparam int TMO_W = $clog2(`DBG_CMD_TIMEOUT);
   localparam logic [TMO_W-1:0] TMO_LAST = TMO_W'(`DBG_CMD_TIMEOUT - 1);

   cmd_state_t      state_q;
   dbg_cmd_t        cmd_q;
   logic [1:0]      byte_cnt_q;
   logic [TMO_W-1:0] timer_q;
   logic            cyc_q;
   logic            cpu_rst_q;
   logic            tx_start_q;
   byte_t           tx_byte_q;
   wb_addr_t        adr_q;
   wb_data_t        dat_q;
   // Reply bytes leave from the top of this word
   wb_data_t        reply_q;
   logic [2:0]      reply_cnt_q;
   logic            cmd_wait;
   logic            timeout;

   // States that wait for more bytes of a command
   assign cmd_wait = (state_q == ADDR) || (state_q == DATA) || (state_q == RST_ARG);
   assign timeout  = cmd_wait && (timer_q == TMO_LAST);

   always_ff @(posedge clk) begin
      if (reset_i || !cmd_wait || rx_valid_i) begin
         timer_q <= '0;
      end else begin
         timer_q <= timer_q + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q     <= IDLE;
         cmd_q       <= CMD_WRITE;
         byte_cnt_q  <= '0;
         cyc_q       <= 1'b0;
         cpu_rst_q   <= 1'b1;
         tx_start_q  <= 1'b0;
         reply_cnt_q <= '0;
      end else begin
         tx_start_q <= 1'b0;
         case (state_q)
            IDLE: begin
               byte_cnt_q <= '0;
               if (rx_valid_i) begin
                  cmd_q <= dbg_cmd_t'(rx_byte_i);
                  case (rx_byte_i)
                     CMD_WRITE, CMD_READ: state_q <= ADDR;
                     CMD_CPU_RST:         state_q <= RST_ARG;
                     default: begin
                        reply_q     <= {REPLY_ERR, 24'h0};
                        reply_cnt_q <= 3'd1;
                        state_q     <= REPLY;
                     end
                  endcase
               end
            end
            ADDR: begin
               if (rx_valid_i) begin
                  adr_q      <= {adr_q[7:0], rx_byte_i};
                  byte_cnt_q <= byte_cnt_q + 2'd1;
                  if (byte_cnt_q == 2'd1) begin
                     byte_cnt_q <= '0;
                     if (cmd_q == CMD_WRITE) begin
                        state_q <= DATA;
                     end else begin
                        cyc_q   <= 1'b1;
                        state_q <= BUS;
                     end
                  end
               end else if (timeout) begin
                  state_q <= IDLE;
               end
            end
            DATA: begin
               if (rx_valid_i) begin
                  dat_q      <= {dat_q[23:0], rx_byte_i};
                  byte_cnt_q <= byte_cnt_q + 2'd1;
                  if (byte_cnt_q == 2'd3) begin
                     cyc_q   <= 1'b1;
                     state_q <= BUS;
                  end
               end else if (timeout) begin
                  state_q <= IDLE;
               end
            end
            RST_ARG: begin
               if (rx_valid_i) begin
                  cpu_rst_q   <= rx_byte_i[0];
                  reply_q     <= {REPLY_OK, 24'h0};
                  reply_cnt_q <= 3'd1;
                  state_q     <= REPLY;
               end else if (timeout) begin
                  state_q <= IDLE;
               end
            end
            BUS: begin
               if (wb_ack_i || wb_err_i) begin
                  cyc_q   <= 1'b0;
                  state_q <= REPLY;
                  if (wb_err_i) begin
                     reply_q     <= {REPLY_ERR, 24'h0};
                     reply_cnt_q <= 3'd1;
                  end else if (cmd_q == CMD_WRITE) begin
                     reply_q     <= {REPLY_OK, 24'h0};
                     reply_cnt_q <= 3'd1;
                  end else begin
                     reply_q     <= wb_dat_i;
                     reply_cnt_q <= 3'd4;
                  end
               end
            end
            REPLY: begin
               if (reply_cnt_q == 3'd0) begin
                  state_q <= IDLE;
               end else if (!tx_busy_i && !tx_start_q) begin
                  // Busy rises only a cycle after start, so skip that cycle
                  tx_start_q  <= 1'b1;
                  tx_byte_q   <= reply_q[31:24];
                  reply_q     <= {reply_q[23:0], 8'h00};
                  reply_cnt_q <= reply_cnt_q - 3'd1;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   assign tx_start_o = tx_start_q;
   assign tx_byte_o  = tx_byte_q;
   assign wb_cyc_o   = cyc_q;
   assign wb_stb_o   = cyc_q;
   assign wb_we_o    = (cmd_q == CMD_WRITE);
   assign wb_adr_o   = adr_q;
   assign wb_dat_o   = dat_q;
   assign cpu_rst_o  = cpu_rst_q;

   // Strobe stays up inside the cycle until the slave answers
   a_stb_hold : assert property (@(posedge clk) disable iff (reset_i)
      (wb_stb_o && !wb_ack_i && !wb_err_i) |=> (wb_stb_o && wb_cyc_o));

endmodule

`default_nettype wire

// File: verilog/dbg_pkg.sv
// Shared types of the UART debug subsystem
// Modules use scoped names in their ports and a wildcard import in their body

`default_nettype none

package dbg_pkg;

   // Widths with a meaning
   typedef logic [7:0]  byte_t;
   typedef logic [15:0] wb_addr_t;
   typedef logic [31:0] wb_data_t;

   // First byte of each host command
   typedef enum logic [7:0] {
      CMD_WRITE   = 8'h01,
      CMD_READ    = 8'h02,
      CMD_CPU_RST = 8'h03
   } dbg_cmd_t;

   // Single-byte status replies
   localparam byte_t REPLY_OK  = 8'hA5;
   localparam byte_t REPLY_ERR = 8'hEE;

   // Command decoder states
   typedef enum logic [2:0] {
      IDLE,
      ADDR,
      DATA,
      RST_ARG,
      BUS,
      REPLY
   } cmd_state_t;

endpackage

`default_nettype wire

// File: verilog/dbg_tile_top.sv
// Top level of the UART debug subsystem
// Host UART link into the command decoder, which reaches the RAM and the CPU reset hold

`timescale 1ns/1ns
`default_nettype none

module dbg_tile_top (
   input  logic clk,
   input  logic reset_i,
   input  logic uart_rx_i,
   output logic uart_tx_o,
   output logic cpu_rst_o
);

   import dbg_pkg::*;

   logic     tick;
   byte_t    rx_byte;
   logic     rx_valid;
   byte_t    tx_byte;
   logic     tx_start;
   logic     tx_busy;

   // Wishbone between decoder and RAM
   logic     wb_cyc;
   logic     wb_stb;
   logic     wb_we;
   wb_addr_t wb_adr;
   wb_data_t wb_wdat;
   wb_data_t wb_rdat;
   logic     wb_ack;
   logic     wb_err;

   uart_tick_timer u_tick (
      .clk     (clk),
      .reset_i (reset_i),
      .tick_o  (tick)
   );

   uart_rx u_uart_rx (
      .clk          (clk),
      .reset_i      (reset_i),
      .tick_i       (tick),
      .rx_i         (uart_rx_i),
      .byte_o       (rx_byte),
      .byte_valid_o (rx_valid)
   );

   uart_tx u_uart_tx (
      .clk        (clk),
      .reset_i    (reset_i),
      .tick_i     (tick),
      .tx_start_i (tx_start),
      .tx_byte_i  (tx_byte),
      .tx_o       (uart_tx_o),
      .tx_busy_o  (tx_busy)
   );

   dbg_cmd_fsm u_cmd_fsm (
      .clk        (clk),
      .reset_i    (reset_i),
      .rx_byte_i  (rx_byte),
      .rx_valid_i (rx_valid),
      .tx_busy_i  (tx_busy),
      .tx_byte_o  (tx_byte),
      .tx_start_o (tx_start),
      .wb_cyc_o   (wb_cyc),
      .wb_stb_o   (wb_stb),
      .wb_we_o    (wb_we),
      .wb_adr_o   (wb_adr),
      .wb_dat_o   (wb_wdat),
      .wb_dat_i   (wb_rdat),
      .wb_ack_i   (wb_ack),
      .wb_err_i   (wb_err),
      .cpu_rst_o  (cpu_rst_o)
   );

   wb_ram u_wb_ram (
      .clk      (clk),
      .reset_i  (reset_i),
      .wb_cyc_i (wb_cyc),
      .wb_stb_i (wb_stb),
      .wb_we_i  (wb_we),
      .wb_adr_i (wb_adr),
      .wb_dat_i (wb_wdat),
      .wb_dat_o (wb_rdat),
      .wb_ack_o (wb_ack),
      .wb_err_o (wb_err)
   );

endmodule

`default_nettype wire

// File: verilog/uart_rx.sv
// 8N1 UART receiver with 16x oversampling
// Emits one byte_valid_o strobe at mid stop bit for each good frame

`timescale 1ns/1ns
`default_nettype none

module uart_rx (
   input  logic          clk,
   input  logic          reset_i,
   input  logic          tick_i,
   input  logic          rx_i,
   output dbg_pkg::byte_t byte_o,
   output logic          byte_valid_o
);

   import dbg_pkg::*;

   logic       rx_meta_q;
   logic       rx_sync_q;
   logic       rx_prev_q;
   logic       busy_q;
   logic [3:0] tick_cnt_q;
   // 0 is the start bit, 1 to 8 the data bits, 9 the stop bit
   logic [3:0] bit_cnt_q;
   byte_t      shift_q;
   logic       valid_q;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         rx_meta_q  <= 1'b1;
         rx_sync_q  <= 1'b1;
         rx_prev_q  <= 1'b1;
         busy_q     <= 1'b0;
         tick_cnt_q <= '0;
         bit_cnt_q  <= '0;
         valid_q    <= 1'b0;
      end else begin
         rx_meta_q <= rx_i;
         rx_sync_q <= rx_meta_q;
         rx_prev_q <= rx_sync_q;
         valid_q   <= 1'b0;
         if (!busy_q) begin
            // Falling edge opens a frame
            if (rx_prev_q && !rx_sync_q) begin
               busy_q     <= 1'b1;
               tick_cnt_q <= '0;
               bit_cnt_q  <= '0;
            end
         end else if (tick_i) begin
            if (bit_cnt_q == 4'd0 && tick_cnt_q == 4'd7) begin
               // Mid start bit, glitches are dropped here
               tick_cnt_q <= '0;
               if (rx_sync_q) begin
                  busy_q <= 1'b0;
               end else begin
                  bit_cnt_q <= 4'd1;
               end
            end else if (tick_cnt_q == 4'd15) begin
               tick_cnt_q <= '0;
               if (bit_cnt_q == 4'd9) begin
                  busy_q  <= 1'b0;
                  valid_q <= rx_sync_q;
               end else begin
                  shift_q   <= {rx_sync_q, shift_q[7:1]};
                  bit_cnt_q <= bit_cnt_q + 4'd1;
               end
            end else begin
               tick_cnt_q <= tick_cnt_q + 4'd1;
            end
         end
      end
   end

   assign byte_o       = shift_q;
   assign byte_valid_o = valid_q;

   a_valid_single : assert property (@(posedge clk) disable iff (reset_i)
      byte_valid_o |=> !byte_valid_o);

endmodule

`default_nettype wire

// File: verilog/uart_tick_timer.sv
// Oversample tick generator for the UART receiver and transmitter
// One tick_o pulse every DBG_CLKS_PER_TICK clocks, shared by both directions

`timescale 1ns/1ns
`default_nettype none

`include "dbg_cfg.svh"

module uart_tick_timer (
   input  logic clk,
   input  logic reset_i,
   output logic tick_o
);

   localparam int CLKS     = `DBG_CLKS_PER_TICK;
   localparam int CNT_W    = (CLKS > 1) ? $clog2(CLKS) : 1;
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS - 1);

   logic [CNT_W-1:0] cnt_q;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         cnt_q <= '0;
      end else if (cnt_q == CNT_LAST) begin
         cnt_q <= '0;
      end else begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   // Pulse on the last count of each period
   assign tick_o = (cnt_q == CNT_LAST);

endmodule

`default_nettype wire

// File: verilog/uart_tx.sv
// 8N1 UART transmitter
// A tx_start_i pulse loads one byte, tx_busy_o stays high until the stop bit ends

`timescale 1ns/1ns
`default_nettype none

module uart_tx (
   input  logic          clk,
   input  logic          reset_i,
   input  logic          tick_i,
   input  logic          tx_start_i,
   input  dbg_pkg::byte_t tx_byte_i,
   output logic          tx_o,
   output logic          tx_busy_o
);

   logic       busy_q;
   logic [9:0] frame_q;
   logic [3:0] tick_cnt_q;
   logic [3:0] bit_cnt_q;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         busy_q     <= 1'b0;
         tick_cnt_q <= '0;
         bit_cnt_q  <= '0;
      end else if (tx_start_i) begin
         // Stop bit, data LSB first, start bit
         frame_q    <= {1'b1, tx_byte_i, 1'b0};
         busy_q     <= 1'b1;
         tick_cnt_q <= '0;
         bit_cnt_q  <= '0;
      end else if (busy_q && tick_i) begin
         tick_cnt_q <= tick_cnt_q + 4'd1;
         if (tick_cnt_q == 4'd15) begin
            if (bit_cnt_q == 4'd9) begin
               busy_q <= 1'b0;
            end else begin
               frame_q   <= {1'b1, frame_q[9:1]};
               bit_cnt_q <= bit_cnt_q + 4'd1;
            end
         end
      end
   end

   // Line idles high between frames
   assign tx_o      = ~busy_q | frame_q[0];
   assign tx_busy_o = busy_q;

   a_no_start_busy : assert property (@(posedge clk) disable iff (reset_i)
      tx_start_i |-> !tx_busy_o);

endmodule

`default_nettype wire

// File: verilog/wb_ram.sv
// Single-port Wishbone RAM standing in for the tile's external memory
// Answers one cycle after stb, with err_o for word addresses past the array

`timescale 1ns/1ns
`default_nettype none

`include "dbg_cfg.svh"

module wb_ram (
   input  logic              clk,
   input  logic              reset_i,
   input  logic              wb_cyc_i,
   input  logic              wb_stb_i,
   input  logic              wb_we_i,
   input  dbg_pkg::wb_addr_t wb_adr_i,
   input  dbg_pkg::wb_data_t wb_dat_i,
   output dbg_pkg::wb_data_t wb_dat_o,
   output logic              wb_ack_o,
   output logic              wb_err_o
);

   import dbg_pkg::*;

   localparam int RAM_AW = $clog2(`DBG_RAM_WORDS);
   localparam wb_addr_t RAM_LIMIT = wb_addr_t'(`DBG_RAM_WORDS);

   wb_data_t mem [0:`DBG_RAM_WORDS-1];
   wb_data_t rd_q;
   logic     ack_q;
   logic     err_q;
   logic     req;
   logic     in_range;

   // New request only while no answer is on the bus
   assign req      = wb_cyc_i && wb_stb_i && !ack_q && !err_q;
   assign in_range = (wb_adr_i < RAM_LIMIT);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= req && in_range;
         err_q <= req && !in_range;
      end
   end

   always_ff @(posedge clk) begin
      if (req && in_range) begin
         if (wb_we_i) begin
            mem[wb_adr_i[RAM_AW-1:0]] <= wb_dat_i;
         end
         rd_q <= mem[wb_adr_i[RAM_AW-1:0]];
      end
   end

   assign wb_dat_o = rd_q;
   assign wb_ack_o = ack_q;
   assign wb_err_o = err_q;

   a_ack_err_excl : assert property (@(posedge clk) disable iff (reset_i)
      !(wb_ack_o && wb_err_o));

endmodule

`default_nettype wire
